/* include/lpif_settings.svh */
// Link widths and userbit positions for the LPIF-over-AIB link; include before the package
`ifndef LPIF_SETTINGS_SVH
`define LPIF_SETTINGS_SVH

// LPIF flit field widths
`define LPIF_DATA_W     256
`define LPIF_CRC_W      16
// state + protid + data + dvalid + crc + crc_valid + valid
`define LPIF_FLIT_W     281

// PHY channel geometry
`define PHY_W           80
`define PHY_CH          4
// Everything except strobe and marker
`define PHY_PAYLOAD_W   78

// Userbit positions inside every channel word
`define STB_BIT         1
`define MRK_BIT         79

// Online delay programming width
`define DELAY_W         8

`endif

/* source/lpif_pkg.sv */
// Flit and PHY channel word types shared by the link datapath; referenced by scoped name
`default_nettype none

`include "lpif_settings.svh"

package lpif_pkg;

  //////////////////////////////////////////////////////////////////////
  // LPIF flit, MSB first

  // 281 bits total
  typedef struct packed {
    logic [3:0]              state;
    logic [1:0]              protid;
    logic [`LPIF_DATA_W-1:0] data;
    logic                    dvalid;
    logic [`LPIF_CRC_W-1:0]  crc;
    logic                    crc_valid;
    logic                    valid;
  } flit_t;

  //////////////////////////////////////////////////////////////////////
  // PHY side

  // One 80-bit channel word, strobe on bit 1, marker on bit 79
  typedef logic [`PHY_W-1:0] phy_word_t;

  // Four 78-bit payloads back to back
  // Channel n owns bits 78n .. 78n+77
  // Flit in the low 281 bits, top 31 bits zero
  typedef logic [`PHY_CH*`PHY_PAYLOAD_W-1:0] stripe_t;

endpackage

`default_nettype wire

/* source/lpif_link_ctrl.sv */
// Online delay sequencing and strobe/marker userbit gating; one instance in the link top level
`default_nettype none

`include "lpif_settings.svh"

module lpif_link_ctrl (
  input  logic                clk_wr,
  input  logic                rst_n,
  input  logic                tx_online,
  input  logic                rx_online,
  input  logic                tx_stb_userbit,
  input  logic                tx_mrk_userbit,
  input  logic [`DELAY_W-1:0] delay_x_value,
  input  logic [`DELAY_W-1:0] delay_xz_value,
  input  logic [`DELAY_W-1:0] delay_yz_value,
  output logic                tx_online_delay,
  output logic                rx_online_delay,
  output logic                tx_auto_stb_userbit,
  output logic                tx_auto_mrk_userbit
);

  typedef enum logic [1:0] {
    TX_IDLE   = 2'd0,
    TX_XZ     = 2'd1,
    TX_YZ     = 2'd2,
    TX_ONLINE = 2'd3
  } tx_state_t;

  tx_state_t           tx_state;
  tx_state_t           tx_state_nxt;
  tx_state_t           yz_entry_state;
  logic [`DELAY_W-1:0] tx_cnt;
  logic [`DELAY_W-1:0] tx_cnt_nxt;
  logic [`DELAY_W-1:0] yz_entry_cnt;
  logic                sync_en;
  logic [`DELAY_W-1:0] rx_cnt;

  //////////////////////////////////////////////////////////////////////
  // TX sequencing

  // Entry into the yz window, skipped straight to online on zero delay
  always_comb begin
    if (delay_yz_value == '0) begin
      yz_entry_state = TX_ONLINE;
      yz_entry_cnt   = '0;
    end else begin
      yz_entry_state = TX_YZ;
      yz_entry_cnt   = delay_yz_value - 1'b1;
    end
  end

  always_comb begin
    tx_state_nxt = tx_state;
    tx_cnt_nxt   = tx_cnt;
    case (tx_state)
      TX_IDLE: begin
        if (tx_online) begin
          // Zero xz delay opens the userbit window right away
          if (delay_xz_value == '0) begin
            tx_state_nxt = yz_entry_state;
            tx_cnt_nxt   = yz_entry_cnt;
          end else begin
            tx_state_nxt = TX_XZ;
            tx_cnt_nxt   = delay_xz_value - 1'b1;
          end
        end
      end
      TX_XZ: begin
        if (tx_cnt == '0) begin
          tx_state_nxt = yz_entry_state;
          tx_cnt_nxt   = yz_entry_cnt;
        end else begin
          tx_cnt_nxt = tx_cnt - 1'b1;
        end
      end
      TX_YZ: begin
        if (tx_cnt == '0) begin
          tx_state_nxt = TX_ONLINE;
        end else begin
          tx_cnt_nxt = tx_cnt - 1'b1;
        end
      end
      default: begin
        tx_state_nxt = TX_ONLINE;
      end
    endcase
    // Loss of tx_online wins from any state
    if (!tx_online) begin
      tx_state_nxt = TX_IDLE;
      tx_cnt_nxt   = '0;
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= TX_IDLE;
      tx_cnt   <= '0;
    end else begin
      tx_state <= tx_state_nxt;
      tx_cnt   <= tx_cnt_nxt;
    end
  end

  // Strobe and marker enables persist through the yz wait and online
  assign sync_en             = (tx_state == TX_YZ) || (tx_state == TX_ONLINE);
  assign tx_online_delay     = (tx_state == TX_ONLINE);
  assign tx_auto_stb_userbit = tx_stb_userbit & sync_en;
  assign tx_auto_mrk_userbit = tx_mrk_userbit & sync_en;

  //////////////////////////////////////////////////////////////////////
  // RX online delay

  // Up-counter compared against delay_x, holds once online
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_online) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_online_delay) begin
      if (rx_cnt == delay_x_value) begin
        rx_online_delay <= 1'b1;
      end else begin
        rx_cnt <= rx_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/lpif_flit_pack.sv */
// Upstream LPIF fields into a flit, plus the transmitted valid flit counter; used by the link top
`default_nettype none

`include "lpif_settings.svh"

module lpif_flit_pack (
  input  logic                    clk_wr,
  input  logic                    rst_n,
  input  logic                    tx_online_delay,
  input  logic [3:0]              ustrm_state,
  input  logic [1:0]              ustrm_protid,
  input  logic [`LPIF_DATA_W-1:0] ustrm_data,
  input  logic                    ustrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]  ustrm_crc,
  input  logic                    ustrm_crc_valid,
  input  logic                    ustrm_valid,
  output lpif_pkg::flit_t         tx_flit,
  output logic [31:0]             tx_upstream_debug_status
);

  //////////////////////////////////////////////////////////////////////
  // Flit assembly

  // Pure field placement, no state
  always_comb begin
    tx_flit.state     = ustrm_state;
    tx_flit.protid    = ustrm_protid;
    tx_flit.data      = ustrm_data;
    tx_flit.dvalid    = ustrm_dvalid;
    tx_flit.crc       = ustrm_crc;
    tx_flit.crc_valid = ustrm_crc_valid;
    tx_flit.valid     = ustrm_valid;
  end

  //////////////////////////////////////////////////////////////////////
  // Debug status

  // Flits that actually leave on the link
  // Offline flits are replaced by zero payload in lane_tx
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_upstream_debug_status <= '0;
    end else if (ustrm_valid && tx_online_delay) begin
      // Wraps at 2^32
      tx_upstream_debug_status <= tx_upstream_debug_status + 32'd1;
    end
  end

endmodule

`default_nettype wire

/* source/lpif_flit_unpack.sv */
// Received flit into downstream LPIF fields with the rx online gate; used by the link top
`default_nettype none

`include "lpif_settings.svh"

module lpif_flit_unpack (
  input  logic                    clk_wr,
  input  logic                    rst_n,
  input  logic                    rx_online_delay,
  input  lpif_pkg::flit_t         rx_flit,
  output logic [3:0]              dstrm_state,
  output logic [1:0]              dstrm_protid,
  output logic [`LPIF_DATA_W-1:0] dstrm_data,
  output logic                    dstrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]  dstrm_crc,
  output logic                    dstrm_crc_valid,
  output logic                    dstrm_valid,
  output logic [31:0]             rx_downstream_debug_status
);

  //////////////////////////////////////////////////////////////////////
  // Field split

  // Payload fields pass through regardless of link state
  assign dstrm_state  = rx_flit.state;
  assign dstrm_protid = rx_flit.protid;
  assign dstrm_data   = rx_flit.data;
  assign dstrm_crc    = rx_flit.crc;

  // Qualifiers held low until rx side is online
  assign dstrm_dvalid    = rx_flit.dvalid    & rx_online_delay;
  assign dstrm_crc_valid = rx_flit.crc_valid & rx_online_delay;
  assign dstrm_valid     = rx_flit.valid     & rx_online_delay;

  //////////////////////////////////////////////////////////////////////
  // Debug status

  // Counts delivered flits only, i.e. after the gate
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_downstream_debug_status <= '0;
    end else if (dstrm_valid) begin
      rx_downstream_debug_status <= rx_downstream_debug_status + 32'd1;
    end
  end

endmodule

`default_nettype wire

/* source/lpif_lane_tx.sv */
// Flit striped over the four transmit channel words with strobe and marker; used by the link top
`default_nettype none

`include "lpif_settings.svh"

module lpif_lane_tx (
  input  logic                clk_wr,
  input  logic                rst_n,
  input  logic                tx_online_delay,
  input  logic                tx_auto_stb_userbit,
  input  logic                tx_auto_mrk_userbit,
  input  lpif_pkg::flit_t     tx_flit,
  output lpif_pkg::phy_word_t tx_phy0,
  output lpif_pkg::phy_word_t tx_phy1,
  output lpif_pkg::phy_word_t tx_phy2,
  output lpif_pkg::phy_word_t tx_phy3
);

  localparam int STRIPE_W = $bits(lpif_pkg::stripe_t);

  lpif_pkg::stripe_t   stripe;
  lpif_pkg::phy_word_t word_q [`PHY_CH];

  // Payload on bit 0 and bits 2..78, userbits in their fixed slots
  function automatic lpif_pkg::phy_word_t build_word(
    input logic [`PHY_PAYLOAD_W-1:0] payload,
    input logic                      stb,
    input logic                      mrk
  );
    lpif_pkg::phy_word_t w;
    w                         = '0;
    w[0]                      = payload[0];
    w[`MRK_BIT-1:`STB_BIT+1]  = payload[`PHY_PAYLOAD_W-1:1];
    w[`STB_BIT]               = stb;
    w[`MRK_BIT]               = mrk;
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stripe and channel registers

  // Zero-extend flit to the full stripe, blank while offline
  assign stripe = tx_online_delay ?
                  {{(STRIPE_W-`LPIF_FLIT_W){1'b0}}, tx_flit} : '0;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      for (int n = 0; n < `PHY_CH; n++) begin
        word_q[n] <= '0;
      end
    end else begin
      // Userbits keep following ctrl even with blank payload
      for (int n = 0; n < `PHY_CH; n++) begin
        word_q[n] <= build_word(stripe[n*`PHY_PAYLOAD_W +: `PHY_PAYLOAD_W],
                                tx_auto_stb_userbit, tx_auto_mrk_userbit);
      end
    end
  end

  assign tx_phy0 = word_q[0];
  assign tx_phy1 = word_q[1];
  assign tx_phy2 = word_q[2];
  assign tx_phy3 = word_q[3];

endmodule

`default_nettype wire

/* source/lpif_lane_rx.sv */
// Four receive channel words reassembled into a flit with userbits removed; used by the link top
`default_nettype none

`include "lpif_settings.svh"

module lpif_lane_rx (
  input  logic                clk_wr,
  input  logic                rst_n,
  input  lpif_pkg::phy_word_t rx_phy0,
  input  lpif_pkg::phy_word_t rx_phy1,
  input  lpif_pkg::phy_word_t rx_phy2,
  input  lpif_pkg::phy_word_t rx_phy3,
  output lpif_pkg::flit_t     rx_flit
);

  lpif_pkg::stripe_t stripe;

  // Inverse of the tx word build, strobe and marker dropped
  function automatic logic [`PHY_PAYLOAD_W-1:0] strip_word(
    input lpif_pkg::phy_word_t w
  );
    return {w[`MRK_BIT-1:`STB_BIT+1], w[0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reassembly

  // Channel 0 in the low bits
  assign stripe = {strip_word(rx_phy3),
                   strip_word(rx_phy2),
                   strip_word(rx_phy1),
                   strip_word(rx_phy0)};

  // Upper stripe bits are padding and never reach the flit
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_flit <= '0;
    end else begin
      rx_flit <= lpif_pkg::flit_t'(stripe[`LPIF_FLIT_W-1:0]);
    end
  end

endmodule

`default_nettype wire

/* source/lpif_link_top.sv */
// LPIF-over-AIB slave logic link top level; instantiate as the DUT with PHY channels on the outside
`default_nettype none

`include "lpif_settings.svh"

module lpif_link_top (
  input  logic                    clk_wr,
  input  logic                    rst_n,

  // Link control
  input  logic                    tx_online,
  input  logic                    rx_online,

  // PHY channels
  output lpif_pkg::phy_word_t     tx_phy0,
  input  lpif_pkg::phy_word_t     rx_phy0,
  output lpif_pkg::phy_word_t     tx_phy1,
  input  lpif_pkg::phy_word_t     rx_phy1,
  output lpif_pkg::phy_word_t     tx_phy2,
  input  lpif_pkg::phy_word_t     rx_phy2,
  output lpif_pkg::phy_word_t     tx_phy3,
  input  lpif_pkg::phy_word_t     rx_phy3,

  // Downstream LPIF
  output logic [3:0]              dstrm_state,
  output logic [1:0]              dstrm_protid,
  output logic [`LPIF_DATA_W-1:0] dstrm_data,
  output logic                    dstrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]  dstrm_crc,
  output logic                    dstrm_crc_valid,
  output logic                    dstrm_valid,

  // Upstream LPIF
  input  logic [3:0]              ustrm_state,
  input  logic [1:0]              ustrm_protid,
  input  logic [`LPIF_DATA_W-1:0] ustrm_data,
  input  logic                    ustrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]  ustrm_crc,
  input  logic                    ustrm_crc_valid,
  input  logic                    ustrm_valid,

  // Debug
  output logic [31:0]             rx_downstream_debug_status,
  output logic [31:0]             tx_upstream_debug_status,

  // Userbits and delay programming
  input  logic                    tx_mrk_userbit,
  input  logic                    tx_stb_userbit,
  input  logic [`DELAY_W-1:0]     delay_x_value,
  input  logic [`DELAY_W-1:0]     delay_xz_value,
  input  logic [`DELAY_W-1:0]     delay_yz_value
);

  lpif_pkg::flit_t tx_flit;
  lpif_pkg::flit_t rx_flit;
  logic            tx_online_delay;
  logic            rx_online_delay;
  logic            tx_auto_stb_userbit;
  logic            tx_auto_mrk_userbit;

  //////////////////////////////////////////////////////////////////////
  // Online sequencing

  lpif_link_ctrl ctrl_i (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .delay_x_value       (delay_x_value),
    .delay_xz_value      (delay_xz_value),
    .delay_yz_value      (delay_yz_value),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  //////////////////////////////////////////////////////////////////////
  // Upstream path, one register stage

  lpif_flit_pack pack_i (
    .clk_wr                   (clk_wr),
    .rst_n                    (rst_n),
    .tx_online_delay          (tx_online_delay),
    .ustrm_state              (ustrm_state),
    .ustrm_protid             (ustrm_protid),
    .ustrm_data               (ustrm_data),
    .ustrm_dvalid             (ustrm_dvalid),
    .ustrm_crc                (ustrm_crc),
    .ustrm_crc_valid          (ustrm_crc_valid),
    .ustrm_valid              (ustrm_valid),
    .tx_flit                  (tx_flit),
    .tx_upstream_debug_status (tx_upstream_debug_status)
  );

  lpif_lane_tx lane_tx_i (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online_delay     (tx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_flit             (tx_flit),
    .tx_phy0             (tx_phy0),
    .tx_phy1             (tx_phy1),
    .tx_phy2             (tx_phy2),
    .tx_phy3             (tx_phy3)
  );

  //////////////////////////////////////////////////////////////////////
  // Downstream path, one register stage

  lpif_lane_rx lane_rx_i (
    .clk_wr  (clk_wr),
    .rst_n   (rst_n),
    .rx_phy0 (rx_phy0),
    .rx_phy1 (rx_phy1),
    .rx_phy2 (rx_phy2),
    .rx_phy3 (rx_phy3),
    .rx_flit (rx_flit)
  );

  lpif_flit_unpack unpack_i (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .rx_online_delay            (rx_online_delay),
    .rx_flit                    (rx_flit),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

endmodule

`default_nettype wire

/* verification/lpif_link_tb.sv */
// Loopback testbench for the LPIF link top level; compile through vlog.f with lpif_link_tb as top
`default_nettype none

`include "lpif_settings.svh"

module lpif_link_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROWS        = 12;
  localparam int X_DLY       = 3;
  localparam int XZ_DLY      = 2;
  localparam int YZ_DLY      = 4;
  localparam int RST_CYCLES  = 10;
  localparam int CLK_PERIOD  = 8;
  localparam int WATCHDOG_NS = (RST_CYCLES + X_DLY + XZ_DLY + YZ_DLY + ROWS + 50) * CLK_PERIOD;
  // Table starts before tx_online_delay, so the first rows go out blank
  localparam int BRINGUP_CYCLES = 5;
  // rx comes up under live rows, so the valid gate meets real flits
  localparam int RX_START_ROW   = 2;
  // Compare width, one full stripe
  localparam int CHK_W       = `PHY_CH * `PHY_PAYLOAD_W;
  localparam int PAD_W       = CHK_W - `LPIF_FLIT_W;

  logic                    clk_wr;
  logic                    rst_n;
  logic                    tx_online;
  logic                    rx_online;
  logic                    tx_stb_userbit;
  logic                    tx_mrk_userbit;
  logic [`DELAY_W-1:0]     delay_x_value;
  logic [`DELAY_W-1:0]     delay_xz_value;
  logic [`DELAY_W-1:0]     delay_yz_value;
  logic [3:0]              ustrm_state;
  logic [1:0]              ustrm_protid;
  logic [`LPIF_DATA_W-1:0] ustrm_data;
  logic                    ustrm_dvalid;
  logic [`LPIF_CRC_W-1:0]  ustrm_crc;
  logic                    ustrm_crc_valid;
  logic                    ustrm_valid;
  logic [`PHY_W-1:0]       tx_phy0;
  logic [`PHY_W-1:0]       tx_phy1;
  logic [`PHY_W-1:0]       tx_phy2;
  logic [`PHY_W-1:0]       tx_phy3;
  logic [`PHY_W-1:0]       rx_phy0;
  logic [`PHY_W-1:0]       rx_phy1;
  logic [`PHY_W-1:0]       rx_phy2;
  logic [`PHY_W-1:0]       rx_phy3;
  logic [3:0]              dstrm_state;
  logic [1:0]              dstrm_protid;
  logic [`LPIF_DATA_W-1:0] dstrm_data;
  logic                    dstrm_dvalid;
  logic [`LPIF_CRC_W-1:0]  dstrm_crc;
  logic                    dstrm_crc_valid;
  logic                    dstrm_valid;
  logic [31:0]             rx_downstream_debug_status;
  logic [31:0]             tx_upstream_debug_status;

  // Stimulus table
  logic [3:0]              row_state       [ROWS];
  logic [1:0]              row_protid      [ROWS];
  logic [`LPIF_DATA_W-1:0] row_data        [ROWS];
  logic                    row_dvalid      [ROWS];
  logic [`LPIF_CRC_W-1:0]  row_crc         [ROWS];
  logic                    row_crc_valid   [ROWS];
  logic                    row_valid       [ROWS];
  logic                    row_sent_online [ROWS];

  // Reference model state
  int                      tx_edges;
  int                      rx_edges;
  logic                    tx_sync_exp;
  logic                    tx_online_exp;
  logic                    rx_online_exp;
  logic [CHK_W-1:0]        cur_stripe;
  logic [`PHY_W-1:0]       exp_phy [`PHY_CH];

  int                      errors;
  int                      checks;
  int                      exp_tx_count;
  int                      exp_rx_count;
  integer                  seed;

  // External loopback
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;
  assign rx_phy2 = tx_phy2;
  assign rx_phy3 = tx_phy3;

  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

  lpif_link_top dut_i (
    .clk_wr (clk_wr), .rst_n (rst_n), .tx_online (tx_online), .rx_online (rx_online),
    .tx_phy0 (tx_phy0), .rx_phy0 (rx_phy0), .tx_phy1 (tx_phy1), .rx_phy1 (rx_phy1),
    .tx_phy2 (tx_phy2), .rx_phy2 (rx_phy2), .tx_phy3 (tx_phy3), .rx_phy3 (rx_phy3),
    .dstrm_state (dstrm_state), .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data),
    .dstrm_dvalid (dstrm_dvalid), .dstrm_crc (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid), .dstrm_valid (dstrm_valid),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data),
    .ustrm_dvalid (ustrm_dvalid), .ustrm_crc (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid), .ustrm_valid (ustrm_valid),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status (tx_upstream_debug_status),
    .tx_mrk_userbit (tx_mrk_userbit), .tx_stb_userbit (tx_stb_userbit),
    .delay_x_value (delay_x_value), .delay_xz_value (delay_xz_value),
    .delay_yz_value (delay_yz_value)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model

  // Field order from the MSB, padded to the full stripe
  function automatic logic [CHK_W-1:0] make_stripe(
    input logic [3:0]              st,
    input logic [1:0]              pid,
    input logic [`LPIF_DATA_W-1:0] data,
    input logic                    dv,
    input logic [`LPIF_CRC_W-1:0]  crc,
    input logic                    cv,
    input logic                    v
  );
    return {{PAD_W{1'b0}}, st, pid, data, dv, crc, cv, v};
  endfunction

  // Marker on top, strobe on bit 1, payload around them
  function automatic logic [`PHY_W-1:0] make_word(
    input logic [`PHY_PAYLOAD_W-1:0] slice,
    input logic                      stb,
    input logic                      mrk
  );
    return {mrk, slice[`PHY_PAYLOAD_W-1:1], stb, slice[0]};
  endfunction

  assign cur_stripe = make_stripe(ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                                  ustrm_crc, ustrm_crc_valid, ustrm_valid);

  // Delays count from the first edge that sees online high
  assign tx_sync_exp   = (tx_edges >= XZ_DLY + 1);
  assign tx_online_exp = (tx_edges >= XZ_DLY + YZ_DLY + 1);
  assign rx_online_exp = (rx_edges >= X_DLY + 1);

  // Channel words one register stage behind the control levels
  always @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_edges <= 0;
      rx_edges <= 0;
      for (int n = 0; n < `PHY_CH; n++) begin
        exp_phy[n] <= '0;
      end
    end else begin
      for (int n = 0; n < `PHY_CH; n++) begin
        exp_phy[n] <= make_word(
          tx_online_exp ? cur_stripe[n*`PHY_PAYLOAD_W +: `PHY_PAYLOAD_W] : '0,
          tx_stb_userbit & tx_sync_exp, tx_mrk_userbit & tx_sync_exp);
      end
      tx_edges <= tx_online ? tx_edges + 1 : 0;
      rx_edges <= rx_online ? rx_edges + 1 : 0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checks

  task automatic check_value(input string name, input logic [CHK_W-1:0] actual,
                             input logic [CHK_W-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0d ns %s: actual %0h expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic fill_table();
    for (int r = 0; r < ROWS; r++) begin
      row_state[r]  = 4'($random(seed));
      row_protid[r] = 2'($random(seed));
      for (int w = 0; w < `LPIF_DATA_W / 32; w++) begin
        row_data[r][w*32 +: 32] = $random(seed);
      end
      row_dvalid[r]      = 1'($random(seed));
      row_crc[r]         = 16'($random(seed));
      row_crc_valid[r]   = 1'($random(seed));
      // Every fourth row idle
      row_valid[r]       = (r % 4 != 3);
      row_sent_online[r] = 1'b0;
    end
  endtask

  // All ones except valid, so blanking is visible
  task automatic drive_filler();
    ustrm_state     = '1;
    ustrm_protid    = '1;
    ustrm_data      = '1;
    ustrm_dvalid    = 1'b1;
    ustrm_crc       = '1;
    ustrm_crc_valid = 1'b1;
    ustrm_valid     = 1'b0;
  endtask

  task automatic drive_row(input int r);
    ustrm_state        = row_state[r];
    ustrm_protid       = row_protid[r];
    ustrm_data         = row_data[r];
    ustrm_dvalid       = row_dvalid[r];
    ustrm_crc          = row_crc[r];
    ustrm_crc_valid    = row_crc_valid[r];
    ustrm_valid        = row_valid[r];
    // tx level seen by lane_tx at the next edge
    row_sent_online[r] = tx_online_exp;
    if (tx_online_exp && row_valid[r]) begin
      exp_tx_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  task automatic check_phy();
    check_value("tx_phy0", CHK_W'(tx_phy0), CHK_W'(exp_phy[0]));
    check_value("tx_phy1", CHK_W'(tx_phy1), CHK_W'(exp_phy[1]));
    check_value("tx_phy2", CHK_W'(tx_phy2), CHK_W'(exp_phy[2]));
    check_value("tx_phy3", CHK_W'(tx_phy3), CHK_W'(exp_phy[3]));
  endtask

  // Blank fields if sent offline, valid bits gated by rx online
  task automatic check_dstrm(input int r);
    logic on;
    logic gate;
    on   = row_sent_online[r];
    gate = rx_online_exp;
    check_value("dstrm_state", CHK_W'(dstrm_state), CHK_W'(on ? row_state[r] : 4'd0));
    check_value("dstrm_protid", CHK_W'(dstrm_protid), CHK_W'(on ? row_protid[r] : 2'd0));
    check_value("dstrm_data", CHK_W'(dstrm_data), CHK_W'(on ? row_data[r] : '0));
    check_value("dstrm_crc", CHK_W'(dstrm_crc), CHK_W'(on ? row_crc[r] : '0));
    check_value("dstrm_dvalid", CHK_W'(dstrm_dvalid), CHK_W'(on & gate & row_dvalid[r]));
    check_value("dstrm_crc_valid", CHK_W'(dstrm_crc_valid),
                CHK_W'(on & gate & row_crc_valid[r]));
    check_value("dstrm_valid", CHK_W'(dstrm_valid), CHK_W'(on & gate & row_valid[r]));
    if (on && gate && row_valid[r]) begin
      exp_rx_count++;
    end
  endtask

  initial begin
    errors          = 0;
    checks          = 0;
    exp_tx_count    = 0;
    exp_rx_count    = 0;
    seed            = 15245;
    clk_wr          = 1'b0;
    rst_n           = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    tx_stb_userbit  = 1'b0;
    tx_mrk_userbit  = 1'b0;
    delay_x_value   = `DELAY_W'(X_DLY);
    delay_xz_value  = `DELAY_W'(XZ_DLY);
    delay_yz_value  = `DELAY_W'(YZ_DLY);
    drive_filler();
    fill_table();

    // Reset values
    repeat (RST_CYCLES) @(posedge clk_wr);
    #1;
    check_phy();
    check_value("tx_upstream_debug_status", CHK_W'(tx_upstream_debug_status), '0);
    check_value("rx_downstream_debug_status", CHK_W'(rx_downstream_debug_status), '0);
    check_value("dstrm_valid", CHK_W'(dstrm_valid), '0);
    rst_n = 1'b1;

    // tx bring-up with both userbits requested
    tx_stb_userbit = 1'b1;
    tx_mrk_userbit = 1'b1;
    tx_online      = 1'b1;
    repeat (BRINGUP_CYCLES) begin
      next_cycle();
      check_phy();
    end
    check_value("tx_phy0 strobe", CHK_W'(tx_phy0[`STB_BIT]), CHK_W'(1'b1));
    check_value("tx_phy3 marker", CHK_W'(tx_phy3[`MRK_BIT]), CHK_W'(1'b1));

    // Table rows while tx finishes the yz wait and rx comes online
    for (int i = 0; i <= ROWS; i++) begin
      if (i < ROWS) begin
        drive_row(i);
      end else begin
        drive_filler();
      end
      if (i == RX_START_ROW) begin
        rx_online = 1'b1;
      end
      next_cycle();
      check_phy();
      if (i >= 1) begin
        check_dstrm(i - 1);
      end
    end
    drive_filler();
    next_cycle();
    check_phy();
    check_value("tx_upstream_debug_status", CHK_W'(tx_upstream_debug_status),
                CHK_W'(32'(exp_tx_count)));
    check_value("rx_downstream_debug_status", CHK_W'(rx_downstream_debug_status),
                CHK_W'(32'(exp_rx_count)));

    // tx_online drop blanks payload and userbits
    tx_online = 1'b0;
    for (int k = 1; k <= 3; k++) begin
      next_cycle();
      check_phy();
      if (k == 2) begin
        check_value("tx_phy0 after drop", CHK_W'(tx_phy0), '0);
        check_value("tx_phy3 after drop", CHK_W'(tx_phy3), '0);
      end
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, test sequence did not complete (%0d errors so far)",
             WATCHDOG_NS, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
source/lpif_pkg.sv
source/lpif_link_ctrl.sv
source/lpif_flit_pack.sv
source/lpif_flit_unpack.sv
source/lpif_lane_tx.sv
source/lpif_lane_rx.sv
source/lpif_link_top.sv
verification/lpif_link_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the LPIF link testbench with Verilator, run it and judge the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f vlog.f \
  --top-module lpif_link_tb \
  -o lpif_link_sim

sim_out=$(./obj_dir/lpif_link_sim)
echo "$sim_out"

if grep -q "SIMULATION PASSED" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
